// ==== lsu_pkg.sv ====
package lsu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int TAG_W  = 4;
    localparam int RD_W   = 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [RD_W-1:0]   rd_idx_t;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } lsu_op_e;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } ls_size_e;

    // Halves must not cross a word, words must be word aligned.
    function automatic logic is_misaligned(ls_size_e size, logic [1:0] off);
        case (size)
            HALF:    return off == 2'b11;
            WORD:    return off != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // Byte lanes touched by an access. Zero for a misaligned one.
    function automatic strb_t lane_strobe(ls_size_e size, logic [1:0] off);
        if (is_misaligned(size, off)) begin
            return strb_t'(0);
        end
        case (size)
            BYTE:    return strb_t'(4'b0001) << off;
            HALF:    return strb_t'(4'b0011) << off;
            default: return strb_t'(4'b1111);
        endcase
    endfunction

endpackage

// ==== lsu_mem_port.sv ====
module lsu_mem_port (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic start_i,
    output logic req_o,
    input  logic ack_i,
    output logic done_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ_HI,
        WAIT_ACK_LO
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = REQ_HI;
                end
            end
            REQ_HI: begin
                // Drop req once the memory has seen it.
                if (ack_i) begin
                    state_d = WAIT_ACK_LO;
                end
            end
            WAIT_ACK_LO: begin
                if (!ack_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_o = state_q == REQ_HI;

    // Transfer ends on the falling ack.
    assign done_o = (state_q == WAIT_ACK_LO) && !ack_i;

endmodule

// ==== lsu_agen.sv ====
module lsu_agen (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               inst_valid_i,
    input  lsu_pkg::lsu_op_e   inst_op_i,
    input  lsu_pkg::ls_size_e  inst_size_i,
    input  logic               inst_unsigned_i,
    input  lsu_pkg::addr_t     inst_base_i,
    input  lsu_pkg::data_t     inst_imm_i,
    input  lsu_pkg::data_t     inst_wdata_i,
    input  lsu_pkg::rd_idx_t   inst_rd_i,
    input  lsu_pkg::tag_t      inst_tag_i,
    output logic               inst_ready_o,
    output logic               ag_valid_o,
    output lsu_pkg::lsu_op_e   ag_op_o,
    output lsu_pkg::addr_t     ag_addr_o,
    output lsu_pkg::strb_t     ag_strb_o,
    output lsu_pkg::data_t     ag_wdata_o,
    output lsu_pkg::ls_size_e  ag_size_o,
    output logic               ag_unsigned_o,
    output lsu_pkg::rd_idx_t   ag_rd_o,
    output lsu_pkg::tag_t      ag_tag_o,
    input  logic               hold_i,
    output logic               exc_valid_o,
    output lsu_pkg::tag_t      exc_tag_o
);

    logic              valid_q;
    lsu_pkg::lsu_op_e  op_q;
    lsu_pkg::ls_size_e size_q;
    logic              unsigned_q;
    lsu_pkg::addr_t    base_q;
    lsu_pkg::data_t    imm_q;
    lsu_pkg::data_t    wdata_q;
    lsu_pkg::rd_idx_t  rd_q;
    lsu_pkg::tag_t     tag_q;

    lsu_pkg::addr_t    addr;
    lsu_pkg::data_t    wdata_lane;
    logic              misaligned;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (inst_ready_o) begin
            valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_ready_o && inst_valid_i) begin
            op_q       <= inst_op_i;
            size_q     <= inst_size_i;
            unsigned_q <= inst_unsigned_i;
            base_q     <= inst_base_i;
            imm_q      <= inst_imm_i;
            wdata_q    <= inst_wdata_i;
            rd_q       <= inst_rd_i;
            tag_q      <= inst_tag_i;
        end
    end

    assign addr       = base_q + imm_q;
    assign misaligned = lsu_pkg::is_misaligned(size_q, addr[1:0]);

    // Keep only the operand bytes, then move them to their lanes.
    always_comb begin
        case (size_q)
            lsu_pkg::BYTE: wdata_lane = lsu_pkg::data_t'(wdata_q[7:0]);
            lsu_pkg::HALF: wdata_lane = lsu_pkg::data_t'(wdata_q[15:0]);
            default:       wdata_lane = wdata_q;
        endcase
        wdata_lane = wdata_lane << {addr[1:0], 3'b000};
    end

    // A misaligned op leaves at once as an exception.
    assign inst_ready_o = !valid_q || misaligned || !hold_i;

    assign ag_valid_o    = valid_q && !misaligned;
    assign ag_op_o       = op_q;
    assign ag_addr_o     = addr;
    assign ag_strb_o     = lsu_pkg::lane_strobe(size_q, addr[1:0]);
    assign ag_wdata_o    = wdata_lane;
    assign ag_size_o     = size_q;
    assign ag_unsigned_o = unsigned_q;
    assign ag_rd_o       = rd_q;
    assign ag_tag_o      = tag_q;

    assign exc_valid_o = valid_q && misaligned;
    assign exc_tag_o   = tag_q;

endmodule

// ==== lsu_store_queue.sv ====
module lsu_store_queue #(
    parameter int SQ_DEPTH = 4
) (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           enq_i,
    input  lsu_pkg::addr_t enq_addr_i,
    input  lsu_pkg::data_t enq_data_i,
    input  lsu_pkg::strb_t enq_strb_i,
    output logic           full_o,
    output logic           empty_o,
    input  logic           retire_i,
    input  lsu_pkg::addr_t lookup_addr_i,
    input  lsu_pkg::strb_t lookup_strb_i,
    output logic           lookup_hit_o,
    output logic           mem_wr_req_o,
    output lsu_pkg::addr_t mem_wr_addr_o,
    output lsu_pkg::data_t mem_wr_data_o,
    output lsu_pkg::strb_t mem_wr_strb_o,
    input  logic           mem_wr_ack_i
);

    localparam int PTR_W = $clog2(SQ_DEPTH);

    // One extra wrap bit per pointer.
    logic [PTR_W:0]    head_q;
    logic [PTR_W:0]    ret_q;
    logic [PTR_W:0]    tail_q;
    logic [SQ_DEPTH-1:0] valid_q;

    lsu_pkg::addr_t addr_q [SQ_DEPTH];
    lsu_pkg::data_t data_q [SQ_DEPTH];
    lsu_pkg::strb_t strb_q [SQ_DEPTH];

    logic           drain_start;
    logic           drain_done;
    logic [PTR_W-1:0] head_idx;
    logic [PTR_W-1:0] tail_idx;

    assign head_idx = head_q[PTR_W-1:0];
    assign tail_idx = tail_q[PTR_W-1:0];

    assign empty_o = head_q == tail_q;
    assign full_o  = (head_q[PTR_W] != tail_q[PTR_W]) && (head_idx == tail_idx);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            ret_q   <= '0;
            tail_q  <= '0;
            valid_q <= '0;
        end else begin
            if (enq_i) begin
                tail_q            <= tail_q + 1'b1;
                valid_q[tail_idx] <= 1'b1;
            end
            if (retire_i) begin
                ret_q <= ret_q + 1'b1;
            end
            if (drain_done) begin
                head_q            <= head_q + 1'b1;
                valid_q[head_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_i) begin
            addr_q[tail_idx] <= enq_addr_i;
            data_q[tail_idx] <= enq_data_i;
            strb_q[tail_idx] <= enq_strb_i;
        end
    end

    // Oldest entry drains once it is retired.
    assign drain_start = ret_q != head_q;

    lsu_mem_port u_wr_port (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (drain_start),
        .req_o    (mem_wr_req_o),
        .ack_i    (mem_wr_ack_i),
        .done_o   (drain_done)
    );

    assign mem_wr_addr_o = {addr_q[head_idx][lsu_pkg::ADDR_W-1:2], 2'b00};
    assign mem_wr_data_o = data_q[head_idx];
    assign mem_wr_strb_o = strb_q[head_idx];

    // Same word and at least one shared byte lane.
    always_comb begin
        lookup_hit_o = 1'b0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (valid_q[i]
                && (addr_q[i][lsu_pkg::ADDR_W-1:2] == lookup_addr_i[lsu_pkg::ADDR_W-1:2])
                && |(strb_q[i] & lookup_strb_i)) begin
                lookup_hit_o = 1'b1;
            end
        end
    end

endmodule

// ==== lsu_load_unit.sv ====
module lsu_load_unit (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              accept_i,
    input  lsu_pkg::addr_t    addr_i,
    input  lsu_pkg::strb_t    strb_i,
    input  lsu_pkg::ls_size_e size_i,
    input  logic              unsigned_i,
    input  lsu_pkg::rd_idx_t  rd_i,
    input  lsu_pkg::tag_t     tag_i,
    output logic              busy_o,
    output lsu_pkg::addr_t    lookup_addr_o,
    output lsu_pkg::strb_t    lookup_strb_o,
    input  logic              lookup_hit_i,
    output logic              mem_rd_req_o,
    output lsu_pkg::addr_t    mem_rd_addr_o,
    input  logic              mem_rd_ack_i,
    input  lsu_pkg::data_t    mem_rd_data_i,
    output logic              rd_we_o,
    output lsu_pkg::rd_idx_t  rd_idx_o,
    output lsu_pkg::data_t    rd_data_o,
    output lsu_pkg::tag_t     rd_tag_o
);

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT_SQ,
        LD_READ
    } ld_state_e;

    ld_state_e         state_q;

    lsu_pkg::addr_t    addr_q;
    lsu_pkg::strb_t    strb_q;
    lsu_pkg::ls_size_e size_q;
    logic              unsigned_q;
    lsu_pkg::rd_idx_t  rd_q;
    lsu_pkg::tag_t     tag_q;
    lsu_pkg::data_t    rdata_q;

    logic              rd_start;
    logic              rd_done;
    lsu_pkg::data_t    shifted;

    // Read may go out only when no queued store covers our bytes.
    assign rd_start = (state_q == LD_WAIT_SQ) && !lookup_hit_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= LD_IDLE;
        end else begin
            case (state_q)
                LD_IDLE:    if (accept_i) state_q <= LD_WAIT_SQ;
                LD_WAIT_SQ: if (rd_start) state_q <= LD_READ;
                LD_READ:    if (rd_done)  state_q <= LD_IDLE;
                default:    state_q <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            addr_q     <= addr_i;
            strb_q     <= strb_i;
            size_q     <= size_i;
            unsigned_q <= unsigned_i;
            rd_q       <= rd_i;
            tag_q      <= tag_i;
        end
        if ((state_q == LD_READ) && mem_rd_ack_i) begin
            rdata_q <= mem_rd_data_i;
        end
    end

    lsu_mem_port u_rd_port (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (rd_start),
        .req_o    (mem_rd_req_o),
        .ack_i    (mem_rd_ack_i),
        .done_o   (rd_done)
    );

    assign busy_o        = state_q != LD_IDLE;
    assign lookup_addr_o = addr_q;
    assign lookup_strb_o = strb_q;
    assign mem_rd_addr_o = {addr_q[lsu_pkg::ADDR_W-1:2], 2'b00};

    // Addressed lane down to bit 0, then extend.
    always_comb begin
        shifted = rdata_q >> {addr_q[1:0], 3'b000};
        case (size_q)
            lsu_pkg::BYTE: begin
                rd_data_o = unsigned_q ? lsu_pkg::data_t'(shifted[7:0])
                                       : {{(lsu_pkg::DATA_W-8){shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::HALF: begin
                rd_data_o = unsigned_q ? lsu_pkg::data_t'(shifted[15:0])
                                       : {{(lsu_pkg::DATA_W-16){shifted[15]}}, shifted[15:0]};
            end
            default: begin
                rd_data_o = shifted;
            end
        endcase
    end

    assign rd_we_o  = rd_done;
    assign rd_idx_o = rd_q;
    assign rd_tag_o = tag_q;

endmodule

// ==== lsu_top.sv ====
module lsu_top #(
    parameter int SQ_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              inst_valid_i,
    input  lsu_pkg::lsu_op_e  inst_op_i,
    input  lsu_pkg::ls_size_e inst_size_i,
    input  logic              inst_unsigned_i,
    input  lsu_pkg::addr_t    inst_base_i,
    input  lsu_pkg::data_t    inst_imm_i,
    input  lsu_pkg::data_t    inst_wdata_i,
    input  lsu_pkg::rd_idx_t  inst_rd_i,
    input  lsu_pkg::tag_t     inst_tag_i,
    output logic              inst_ready_o,
    output logic              exc_valid_o,
    output lsu_pkg::tag_t     exc_tag_o,
    output logic              st_done_o,
    output lsu_pkg::tag_t     st_tag_o,
    input  logic              st_retire_i,
    output logic              sq_empty_o,
    output logic              rd_we_o,
    output lsu_pkg::rd_idx_t  rd_idx_o,
    output lsu_pkg::data_t    rd_data_o,
    output lsu_pkg::tag_t     rd_tag_o,
    output logic              mem_rd_req_o,
    output lsu_pkg::addr_t    mem_rd_addr_o,
    input  logic              mem_rd_ack_i,
    input  lsu_pkg::data_t    mem_rd_data_i,
    output logic              mem_wr_req_o,
    output lsu_pkg::addr_t    mem_wr_addr_o,
    output lsu_pkg::data_t    mem_wr_data_o,
    output lsu_pkg::strb_t    mem_wr_strb_o,
    input  logic              mem_wr_ack_i
);

    logic              ag_valid;
    lsu_pkg::lsu_op_e  ag_op;
    lsu_pkg::addr_t    ag_addr;
    lsu_pkg::strb_t    ag_strb;
    lsu_pkg::data_t    ag_wdata;
    lsu_pkg::ls_size_e ag_size;
    logic              ag_unsigned;
    lsu_pkg::rd_idx_t  ag_rd;
    lsu_pkg::tag_t     ag_tag;

    logic              hold;
    logic              sq_full;
    logic              sq_enq;
    logic              ld_busy;
    logic              ld_accept;
    lsu_pkg::addr_t    lookup_addr;
    lsu_pkg::strb_t    lookup_strb;
    logic              lookup_hit;

    // Stores also wait behind a pending load, so its overlap check sees only older stores.
    assign hold = (ag_op == lsu_pkg::STORE) ? (sq_full || ld_busy) : ld_busy;

    assign sq_enq    = ag_valid && (ag_op == lsu_pkg::STORE) && !hold;
    assign ld_accept = ag_valid && (ag_op == lsu_pkg::LOAD) && !hold;

    assign st_done_o = sq_enq;
    assign st_tag_o  = ag_tag;

    lsu_agen u_agen (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .inst_valid_i    (inst_valid_i),
        .inst_op_i       (inst_op_i),
        .inst_size_i     (inst_size_i),
        .inst_unsigned_i (inst_unsigned_i),
        .inst_base_i     (inst_base_i),
        .inst_imm_i      (inst_imm_i),
        .inst_wdata_i    (inst_wdata_i),
        .inst_rd_i       (inst_rd_i),
        .inst_tag_i      (inst_tag_i),
        .inst_ready_o    (inst_ready_o),
        .ag_valid_o      (ag_valid),
        .ag_op_o         (ag_op),
        .ag_addr_o       (ag_addr),
        .ag_strb_o       (ag_strb),
        .ag_wdata_o      (ag_wdata),
        .ag_size_o       (ag_size),
        .ag_unsigned_o   (ag_unsigned),
        .ag_rd_o         (ag_rd),
        .ag_tag_o        (ag_tag),
        .hold_i          (hold),
        .exc_valid_o     (exc_valid_o),
        .exc_tag_o       (exc_tag_o)
    );

    lsu_store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_store_queue (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .enq_i         (sq_enq),
        .enq_addr_i    (ag_addr),
        .enq_data_i    (ag_wdata),
        .enq_strb_i    (ag_strb),
        .full_o        (sq_full),
        .empty_o       (sq_empty_o),
        .retire_i      (st_retire_i),
        .lookup_addr_i (lookup_addr),
        .lookup_strb_i (lookup_strb),
        .lookup_hit_o  (lookup_hit),
        .mem_wr_req_o  (mem_wr_req_o),
        .mem_wr_addr_o (mem_wr_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .mem_wr_strb_o (mem_wr_strb_o),
        .mem_wr_ack_i  (mem_wr_ack_i)
    );

    lsu_load_unit u_load_unit (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .accept_i      (ld_accept),
        .addr_i        (ag_addr),
        .strb_i        (ag_strb),
        .size_i        (ag_size),
        .unsigned_i    (ag_unsigned),
        .rd_i          (ag_rd),
        .tag_i         (ag_tag),
        .busy_o        (ld_busy),
        .lookup_addr_o (lookup_addr),
        .lookup_strb_o (lookup_strb),
        .lookup_hit_i  (lookup_hit),
        .mem_rd_req_o  (mem_rd_req_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_rd_ack_i  (mem_rd_ack_i),
        .mem_rd_data_i (mem_rd_data_i),
        .rd_we_o       (rd_we_o),
        .rd_idx_o      (rd_idx_o),
        .rd_data_o     (rd_data_o),
        .rd_tag_o      (rd_tag_o)
    );

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model (
    input  logic        clk_i,
    input  logic [2:0]  rd_delay_i,
    input  logic [2:0]  wr_delay_i,
    input  logic        rd_req_i,
    input  logic [31:0] rd_addr_i,
    output logic        rd_ack_o,
    output logic [31:0] rd_data_o,
    input  logic        wr_req_i,
    input  logic [31:0] wr_addr_i,
    input  logic [31:0] wr_data_i,
    input  logic [3:0]  wr_strb_i,
    output logic        wr_ack_o
);

    logic [31:0] mem_q [64];
    logic [2:0]  rd_cnt_q;
    logic [2:0]  wr_cnt_q;

    // Fill word depends on its full byte address.
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem_q[i] = (i * 4) * 32'h9e37_79b9 + 32'h0123_4567;
        end
        rd_ack_o  = 1'b0;
        wr_ack_o  = 1'b0;
        rd_data_o = '0;
        rd_cnt_q  = '0;
        wr_cnt_q  = '0;
    end

    always @(posedge clk_i) begin
        if (!rd_ack_o) begin
            if (rd_req_i) begin
                if (rd_cnt_q >= rd_delay_i) begin
                    rd_ack_o  <= 1'b1;
                    rd_data_o <= mem_q[rd_addr_i[7:2]];
                    rd_cnt_q  <= '0;
                end else begin
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                end
            end
        end else if (!rd_req_i) begin
            rd_ack_o <= 1'b0;
        end
    end

    always @(posedge clk_i) begin
        if (!wr_ack_o) begin
            if (wr_req_i) begin
                if (wr_cnt_q >= wr_delay_i) begin
                    wr_ack_o <= 1'b1;
                    wr_cnt_q <= '0;
                    for (int b = 0; b < 4; b++) begin
                        if (wr_strb_i[b]) begin
                            mem_q[wr_addr_i[7:2]][8*b +: 8] <= wr_data_i[8*b +: 8];
                        end
                    end
                end else begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end
        end else if (!wr_req_i) begin
            wr_ack_o <= 1'b0;
        end
    end

endmodule

// ==== tb_lsu.sv ====
module tb_lsu;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic        op;
        logic [1:0]  size;
        logic        uns;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] wdata;
        logic        exc;
        logic        stall;
    } row_t;

    logic clk_i;
    logic arst_n_i;
    logic inst_valid;
    lsu_pkg::lsu_op_e  inst_op;
    lsu_pkg::ls_size_e inst_size;
    logic        inst_unsigned;
    logic [31:0] inst_base;
    logic [31:0] inst_imm;
    logic [31:0] inst_wdata;
    logic [4:0]  inst_rd;
    logic [3:0]  inst_tag;
    logic        inst_ready;
    logic        exc_valid;
    logic [3:0]  exc_tag;
    logic        st_done;
    logic [3:0]  st_tag;
    logic        st_retire;
    logic        sq_empty;
    logic        rd_we;
    logic [4:0]  rd_idx;
    logic [31:0] rd_data;
    logic [3:0]  rd_tag;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_ack;
    logic [31:0] rd_rdata;
    logic        wr_req;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        wr_ack;
    logic [2:0]  rd_delay;
    logic [2:0]  wr_delay;

    row_t        rows[$];
    logic [7:0]  ref_mem [256];
    logic [7:0]  lfsr_q;
    logic        retire_en;
    int          enqueued;
    int          retired;
    int          gap;
    logic        wr_logged;
    logic        rd_logged;
    logic [67:0] exp_wr[$];
    logic [72:0] exp_ld[$];
    logic [3:0]  exp_exc[$];
    logic [3:0]  exp_st[$];
    int          written[$];

    lsu_top #(.SQ_DEPTH(4)) UUT (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .inst_valid_i(inst_valid), .inst_op_i(inst_op), .inst_size_i(inst_size),
        .inst_unsigned_i(inst_unsigned), .inst_base_i(inst_base), .inst_imm_i(inst_imm),
        .inst_wdata_i(inst_wdata), .inst_rd_i(inst_rd), .inst_tag_i(inst_tag),
        .inst_ready_o(inst_ready), .exc_valid_o(exc_valid), .exc_tag_o(exc_tag),
        .st_done_o(st_done), .st_tag_o(st_tag), .st_retire_i(st_retire),
        .sq_empty_o(sq_empty), .rd_we_o(rd_we), .rd_idx_o(rd_idx), .rd_data_o(rd_data),
        .rd_tag_o(rd_tag), .mem_rd_req_o(rd_req), .mem_rd_addr_o(rd_addr),
        .mem_rd_ack_i(rd_ack), .mem_rd_data_i(rd_rdata), .mem_wr_req_o(wr_req),
        .mem_wr_addr_o(wr_addr), .mem_wr_data_o(wr_data), .mem_wr_strb_o(wr_strb),
        .mem_wr_ack_i(wr_ack)
    );

    tb_mem_model u_mem (
        .clk_i(clk_i), .rd_delay_i(rd_delay), .wr_delay_i(wr_delay),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_ack_o(rd_ack), .rd_data_o(rd_rdata),
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .wr_strb_i(wr_strb), .wr_ack_o(wr_ack)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit taken.
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 8'hb8) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic add_row(input logic op, input logic [1:0] size, input logic uns,
                           input logic [31:0] base, input logic [31:0] imm,
                           input logic [31:0] wdata, input logic exc, input logic stall);
        rows.push_back('{op, size, uns, base, imm, wdata, exc, stall});
    endtask

    // Predict the DUT's effects from the row, then offer it on the input.
    task automatic send_row(input int r);
        row_t        w;
        logic [31:0] a;
        int          n;
        int          waited;
        logic [31:0] v;
        w = rows[r];
        a = w.base + w.imm;
        n = (w.size == 2'd0) ? 1 : ((w.size == 2'd1) ? 2 : 4);
        if (w.exc) begin
            exp_exc.push_back(r[3:0]);
        end else if (w.op) begin
            for (int i = 0; i < n; i++) begin
                ref_mem[a[7:0] + i] = w.wdata[8*i +: 8];
            end
            v = (n == 4) ? w.wdata : (w.wdata & ((32'd1 << (8 * n)) - 1));
            exp_wr.push_back({a[31:2], 2'b00, v << (8 * a[1:0]),
                              4'(((1 << n) - 1) << a[1:0])});
            exp_st.push_back(r[3:0]);
            written.push_back(a[7:2]);
        end else begin
            v = 0;
            for (int i = 0; i < n; i++) begin
                v[8*i +: 8] = ref_mem[a[7:0] + i];
            end
            if (!w.uns && n < 4 && v[8*n-1]) begin
                v = v | ~((32'd1 << (8 * n)) - 1);
            end
            exp_ld.push_back({a[31:2], 2'b00, r[4:0] + 5'd1, r[3:0], v});
        end
        inst_valid    = 1'b1;
        inst_op       = lsu_pkg::lsu_op_e'(w.op);
        inst_size     = lsu_pkg::ls_size_e'(w.size);
        inst_unsigned = w.uns;
        inst_base     = w.base;
        inst_imm      = w.imm;
        inst_wdata    = w.wdata;
        inst_rd       = r[4:0] + 5'd1;
        inst_tag      = r[3:0];
        waited        = 0;
        while (!inst_ready) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("Timeout while waiting for inst_ready_o to accept a row.");
            end
        end
        @(negedge clk_i);
        inst_valid = 1'b0;
    endtask

    // Retire pulses and ack delays share the one LFSR.
    always @(negedge clk_i) begin
        int v;
        st_retire = 1'b0;
        if (arst_n_i && retire_en && retired < enqueued) begin
            if (gap == 0) begin
                st_retire = 1'b1;
                retired++;
                gap = take_bits(2);
            end else begin
                gap--;
            end
        end
        if (st_done) begin
            enqueued++;
        end
        if (!rd_req && !rd_ack) begin
            v = take_bits(3);
            rd_delay = v[2:0];
        end
        if (!wr_req && !wr_ack) begin
            v = take_bits(3);
            wr_delay = v[2:0];
        end
    end

    // Scoreboard for writes, reads, loads, stores and exceptions.
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (wr_req && !wr_logged) begin
                wr_logged = 1'b1;
                if (exp_wr.size() == 0) begin
                    abort_run("Memory write seen with no store expected.");
                end
                check("write address", exp_wr[0][67:36], wr_addr);
                check("write data", exp_wr[0][35:4], wr_data);
                check("write strobe", exp_wr[0][3:0], wr_strb);
                void'(exp_wr.pop_front());
            end else if (!wr_req) begin
                wr_logged = 1'b0;
            end
            if (rd_req && !rd_logged) begin
                rd_logged = 1'b1;
                if (exp_ld.size() == 0) begin
                    abort_run("Memory read seen with no load expected.");
                end
                check("read address", exp_ld[0][72:41], rd_addr);
            end else if (!rd_req) begin
                rd_logged = 1'b0;
            end
            if (rd_we) begin
                if (exp_ld.size() == 0) begin
                    abort_run("Writeback seen with no load expected.");
                end
                check("load rd", exp_ld[0][40:36], rd_idx);
                check("load tag", exp_ld[0][35:32], rd_tag);
                check("load data", exp_ld[0][31:0], rd_data);
                void'(exp_ld.pop_front());
            end
            if (st_done) begin
                if (exp_st.size() == 0) begin
                    abort_run("Store enqueue seen with no store expected.");
                end
                check("store tag", exp_st.pop_front(), st_tag);
            end
            if (exc_valid) begin
                if (exp_exc.size() == 0) begin
                    abort_run("Exception seen with none expected.");
                end
                check("exception tag", exp_exc.pop_front(), exc_tag);
            end
        end
    end

    initial begin
        int waited;
        int stalled;
        logic [31:0] w;
        lfsr_q = 8'd31;
        arst_n_i = 1'b0;
        inst_valid = 1'b0;
        inst_op = lsu_pkg::LOAD;
        inst_size = lsu_pkg::BYTE;
        inst_unsigned = 1'b0;
        inst_base = '0;
        inst_imm = '0;
        inst_wdata = '0;
        inst_rd = '0;
        inst_tag = '0;
        st_retire = 1'b0;
        rd_delay = '0;
        wr_delay = '0;
        retire_en = 1'b1;
        enqueued = 0;
        retired = 0;
        gap = 0;
        wr_logged = 1'b0;
        rd_logged = 1'b0;
        stalled = 0;
        for (int i = 0; i < 256; i++) begin
            w = (i & ~3) * 32'h9e37_79b9 + 32'h0123_4567;
            ref_mem[i] = w[8*(i % 4) +: 8];
        end

        // op, size, unsigned, base, imm, wdata, exception, hold retire
        add_row(1, 2, 0, 32'h40, 32'h0, 32'hdead_beef, 0, 0);
        add_row(0, 2, 0, 32'h3c, 32'h4, 32'h0, 0, 0);
        add_row(1, 0, 0, 32'h50, 32'h0, 32'h0000_0081, 0, 0);
        add_row(1, 0, 0, 32'h50, 32'h1, 32'hffff_ff12, 0, 0);
        add_row(1, 0, 0, 32'h50, 32'h2, 32'h0000_00f3, 0, 0);
        add_row(1, 0, 0, 32'h50, 32'h3, 32'h0000_0044, 0, 0);
        add_row(0, 0, 0, 32'h50, 32'h0, 32'h0, 0, 0);
        add_row(0, 0, 1, 32'h50, 32'h0, 32'h0, 0, 0);
        add_row(0, 0, 0, 32'h52, 32'h0, 32'h0, 0, 0);
        add_row(0, 0, 1, 32'h53, 32'h0, 32'h0, 0, 0);
        add_row(1, 1, 0, 32'h60, 32'h0, 32'h1234_8765, 0, 0);
        add_row(1, 1, 0, 32'h64, 32'h1, 32'h0000_9abc, 0, 0);
        add_row(1, 1, 0, 32'h68, 32'h2, 32'h0000_f00d, 0, 0);
        add_row(0, 1, 0, 32'h60, 32'h0, 32'h0, 0, 0);
        add_row(0, 1, 1, 32'h60, 32'h0, 32'h0, 0, 0);
        add_row(0, 1, 0, 32'h65, 32'h0, 32'h0, 0, 0);
        add_row(0, 1, 0, 32'h6a, 32'h0, 32'h0, 0, 0);
        add_row(0, 1, 0, 32'h70, 32'h3, 32'h0, 1, 0);
        add_row(1, 2, 0, 32'h70, 32'h2, 32'h1111_1111, 1, 0);
        add_row(0, 2, 0, 32'h71, 32'h0, 32'h0, 1, 0);
        add_row(1, 2, 0, 32'h74, 32'h0, 32'hcafe_f00d, 0, 1);
        add_row(0, 0, 0, 32'h74, 32'h1, 32'h0, 0, 1);
        add_row(0, 2, 0, 32'h74, 32'h0, 32'h0, 0, 0);
        add_row(1, 2, 0, 32'h80, 32'h0, 32'h1000_0001, 0, 1);
        add_row(1, 2, 0, 32'h80, 32'h4, 32'h2000_0002, 0, 1);
        add_row(1, 2, 0, 32'h80, 32'h8, 32'h3000_0003, 0, 1);
        add_row(1, 2, 0, 32'h80, 32'hc, 32'h4000_0004, 0, 1);
        add_row(1, 2, 0, 32'h80, 32'h10, 32'h5000_0005, 0, 1);
        add_row(0, 2, 0, 32'h80, 32'h10, 32'h0, 0, 0);
        add_row(0, 2, 0, 32'h80, 32'h0, 32'h0, 0, 0);

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check("ready after reset", 1, inst_ready);
        check("sq_empty after reset", 1, sq_empty);
        check("outputs idle after reset", 0, {exc_valid, st_done, rd_we, rd_req, wr_req});

        for (int r = 0; r < rows.size(); r++) begin
            if (!rows[r].stall && !retire_en) begin
                // A full queue plus a held store must stall the input.
                if (stalled >= 5) begin
                    waited = 0;
                    while (inst_ready) begin
                        @(negedge clk_i);
                        waited++;
                        if (waited > TIMEOUT) begin
                            abort_run("Timeout while waiting for inst_ready_o to fall.");
                        end
                    end
                end
                retire_en = 1'b1;
                stalled = 0;
            end
            if (rows[r].stall) begin
                if (retire_en) begin
                    // Held group starts from an empty queue.
                    waited = 0;
                    while (!sq_empty || st_done) begin
                        @(negedge clk_i);
                        waited++;
                        if (waited > TIMEOUT) begin
                            abort_run("Timeout while waiting for the store queue to empty.");
                        end
                    end
                end
                retire_en = 1'b0;
                stalled += rows[r].op;
            end
            send_row(r);
        end
        retire_en = 1'b1;

        waited = 0;
        while (exp_wr.size() || exp_ld.size() || exp_exc.size() || exp_st.size()
               || !sq_empty || retired != enqueued) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("Timeout while waiting for the store queue to drain.");
            end
        end
        foreach (written[i]) begin
            check("memory word", {ref_mem[written[i]*4+3], ref_mem[written[i]*4+2],
                                  ref_mem[written[i]*4+1], ref_mem[written[i]*4]},
                  u_mem.mem_q[written[i]]);
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
lsu_pkg.sv
lsu_mem_port.sv
lsu_agen.sv
lsu_store_queue.sv
lsu_load_unit.sv
lsu_top.sv
tb_mem_model.sv
tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_mem_port.sv
  - lsu_agen.sv
  - lsu_store_queue.sv
  - lsu_load_unit.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_lsu.sv
